//--- testbench/cpu_stim.txt
# p <addr> <word> memory preload, e <addr> <word> expected final word (all hex)
# m <byte> expected message byte, listed in output order
p 0000 10504041
p 0001 20514041
p 0002 30524041
p 0003 40534041
p 0004 50544041
p 0005 60554042
p 0006 90000048
p 0007 80020000
p 0008 10100001
p 0009 10040405
p 000a 20020203
p 000b 70000902
p 000c 90000069
p 000d a0000000
p 000e 90000021
p 000f f0000000
p 0040 12345678
p 0041 0f0f00f1
p 0042 00000023
p 0200 00001000
p 0201 00000234
p 0202 00000005
p 0203 00000001
p 0204 00000000
p 0205 00000007
e 0050 21435769
e 0051 03255587
e 0052 02040070
e 0053 1f3f56f9
e 0054 1d3b5689
e 0055 91a2b3c0
e 0040 12345678
e 0210 00001234
e 0010 0010ffef
e 0202 00000000
e 0204 00000023
m 48
m 69
m 21

//--- tb.f
source/cpu_pkg.sv
source/cmd_fetch.sv
source/operand_fetch.sv
source/alu_exec.sv
source/result_store.sv
source/bus_owner.sv
source/cpu_core.sv
testbench/tb_cpu_core.sv

//--- Makefile
TOP := tb_cpu_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- testbench/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

  logic              clk;
  logic              rst;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  logic              read_q;
  logic              write_q;
  logic [data_w-1:0] rdata;
  logic              read_dn;
  logic              write_dn;
  logic              bus_busy;
  logic [7:0]        cpu_msg;
  logic              msg_valid;
  logic              halted;

  // memory model state
  logic [data_w-1:0] mem [0:65535];
  logic              pend;
  logic              req_wr;
  logic [addr_w-1:0] req_addr;
  logic [data_w-1:0] req_data;
  int                wait_left;
  logic [31:0]       lfsr = 32'h52e9;

  // expected results from the stim file
  logic [addr_w-1:0] exp_addr [$];
  logic [data_w-1:0] exp_word [$];
  logic [7:0]        exp_msg [$];
  int                preload_cnt = 0;
  int                msg_idx = 0;
  int                mismatch_cnt = 0;
  int                fail_cnt = 0;
  logic              halted_seen;
  logic              stim_loaded;

  cpu_core i_cpu_core (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // unwritten words hold a pattern built from their own address
  task automatic fill_memory();
    for (int i = 0; i < 65536; i++) begin
      mem[i[15:0]] = {i[15:0], ~i[15:0]};
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [31:0] a;
    logic [31:0] w;
    fd = $fopen("testbench/cpu_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file testbench/cpu_stim.txt");
      fail_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 2 && line.getc(0) != "#") begin
        n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, w);
        case (line.getc(0))
          "p": begin
            mem[a[15:0]] = w;
            preload_cnt++;
          end
          "e": begin
            exp_addr.push_back(a[15:0]);
            exp_word.push_back(w);
          end
          "m": exp_msg.push_back(a[7:0]);
          default: begin
            $display("unknown line in the stimulus file: %s", line);
            fail_cnt++;
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  task automatic check_memory();
    foreach (exp_addr[i]) begin
      if (mem[exp_addr[i]] !== exp_word[i]) begin
        $display("mismatch at %0t: mem[%h] is %h, expected %h",
                 $time, exp_addr[i], mem[exp_addr[i]], exp_word[i]);
        mismatch_cnt++;
      end
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
  endtask

  // memory with 1 to 4 cycles of latency, plus bus and message monitor
  always @(posedge clk) begin
    read_dn  <= 1'b0;
    write_dn <= 1'b0;
    if (rst) begin
      pend        = 1'b0;
      halted_seen = 1'b0;
    end else begin
      if ((read_q || write_q) && bus_busy) begin
        $display("%0t: request issued while bus_busy is high", $time);
        fail_cnt++;
      end
      if ((read_q || write_q) && pend) begin
        $display("%0t: new request before the previous access was done", $time);
        fail_cnt++;
      end
      if (read_q && write_q) begin
        $display("%0t: read and write requested in the same cycle", $time);
        fail_cnt++;
      end
      if ((pend || read_dn || write_dn) && !bus_busy) begin
        $display("%0t: bus_busy is low during an access", $time);
        fail_cnt++;
      end
      if (halted_seen && (read_q || write_q)) begin
        $display("%0t: bus request after the core halted", $time);
        fail_cnt++;
      end
      if (halted_seen && !halted) begin
        $display("%0t: halted dropped after it was set", $time);
        fail_cnt++;
      end
      halted_seen = halted;

      if (msg_valid) begin
        if (msg_idx >= exp_msg.size()) begin
          $display("%0t: unexpected extra message %h", $time, cpu_msg);
          fail_cnt++;
        end else if (cpu_msg !== exp_msg[msg_idx]) begin
          $display("mismatch at %0t: message %0d is %h, expected %h",
                   $time, msg_idx, cpu_msg, exp_msg[msg_idx]);
          mismatch_cnt++;
        end
        msg_idx++;
      end

      // two lfsr bits give the latency
      if (read_q || write_q) begin
        pend     = 1'b1;
        req_wr   = write_q;
        req_addr = addr;
        req_data = wdata;
        lfsr      = lfsr_next(lfsr);
        wait_left = 1 + int'(lfsr[0]);
        lfsr      = lfsr_next(lfsr);
        wait_left = wait_left + 2 * int'(lfsr[0]);
      end
      if (pend) begin
        wait_left--;
        if (wait_left == 0) begin
          pend = 1'b0;
          if (req_wr) begin
            mem[req_addr] = req_data;
            write_dn <= 1'b1;
          end else begin
            rdata   <= mem[req_addr];
            read_dn <= 1'b1;
          end
        end
      end
    end
  end

  initial begin
    rst         = 1'b1;
    rdata       = '0;
    read_dn     = 1'b0;
    write_dn    = 1'b0;
    stim_loaded = 1'b0;
    fill_memory();
    load_stim();
    stim_loaded = 1'b1;
    repeat (5) @(posedge clk);
    if (read_q || write_q || bus_busy || msg_valid || halted || cpu_msg != 8'h00) begin
      $display("DUT outputs are not idle during reset");
      fail_cnt++;
    end
    rst <= 1'b0;
    while (!halted) @(posedge clk);
    // keep watching the bus for a while after halt
    repeat (20) @(posedge clk);
    check_memory();
    if (msg_idx != exp_msg.size()) begin
      $display("expected %0d messages but saw %0d", exp_msg.size(), msg_idx);
      fail_cnt++;
    end
    if (pend) begin
      $display("an access was still waiting for its done pulse at the end");
      fail_cnt++;
    end
    print_counts();
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog sized by the program length
  initial begin
    wait (stim_loaded);
    repeat (preload_cnt * 64) @(posedge clk);
    $display("timeout: core did not halt within %0d cycles", preload_cnt * 64);
    fail_cnt++;
    print_counts();
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- source/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  output logic [addr_w-1:0] addr,
  output logic [data_w-1:0] wdata,
  output logic              read_q,
  output logic              write_q,
  input  logic [data_w-1:0] rdata,
  input  logic              read_dn,
  input  logic              write_dn,
  output logic              bus_busy,
  output logic [7:0]        cpu_msg,
  output logic              msg_valid,
  output logic              halted
);

  // fetch stage
  logic              cf_rd_req;
  logic [addr_w-1:0] cf_addr;
  logic              cf_rd_dn;
  logic              cmd_valid;
  cmd_word_u         cmd;

  // operand stage
  logic              of_rd_req;
  logic [addr_w-1:0] of_addr;
  logic              of_rd_dn;
  logic              opnd_valid;
  cmd_word_u         opnd_cmd;
  logic [data_w-1:0] opnd_a;
  logic [data_w-1:0] opnd_b;

  // execute stage
  logic              res_valid;
  cmd_word_u         res_cmd;
  logic [data_w-1:0] result;
  logic              take_jump;

  // store stage
  logic              rs_wr_req;
  logic [addr_w-1:0] rs_addr;
  logic              rs_wr_dn;
  logic [data_w-1:0] rs_wdata;
  logic [addr_w-1:0] base_addr;
  logic              next_valid;
  logic [addr_w-1:0] next_ptr;

  cmd_fetch i_cmd_fetch (.*);

  operand_fetch i_operand_fetch (.*);

  alu_exec i_alu_exec (.*);

  // fetch address doubles as the current command pointer
  result_store i_result_store (
    .*,
    .cmd_ptr (cf_addr),
    .wdata   (rs_wdata)
  );

  bus_owner i_bus_owner (
    .*,
    .wdata_in (rs_wdata)
  );

endmodule

//--- source/bus_owner.sv
`timescale 1ns/1ps

module bus_owner import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              cf_rd_req,
  input  logic [addr_w-1:0] cf_addr,
  input  logic              of_rd_req,
  input  logic [addr_w-1:0] of_addr,
  input  logic              rs_wr_req,
  input  logic [addr_w-1:0] rs_addr,
  input  logic [data_w-1:0] wdata_in,
  output logic [addr_w-1:0] addr,
  output logic [data_w-1:0] wdata,
  output logic              read_q,
  output logic              write_q,
  output logic              bus_busy,
  output logic              cf_rd_dn,
  output logic              of_rd_dn,
  output logic              rs_wr_dn,
  input  logic              read_dn,
  input  logic              write_dn
);

  // one-hot owner: bit 0 fetch, bit 1 operand, bit 2 store
  logic [2:0] owner;
  logic       any_req;

  assign any_req = cf_rd_req | of_rd_req | rs_wr_req;
  assign read_q  = cf_rd_req | of_rd_req;
  assign write_q = rs_wr_req;
  assign wdata   = wdata_in;

  always_comb begin
    if (cf_rd_req) begin
      addr = cf_addr;
    end else if (of_rd_req) begin
      addr = of_addr;
    end else begin
      addr = rs_addr;
    end
  end

  assign cf_rd_dn = read_dn & owner[0];
  assign of_rd_dn = read_dn & owner[1];
  assign rs_wr_dn = write_dn & owner[2];

  always_ff @(posedge clk) begin
    if (rst) begin
      owner    <= '0;
      bus_busy <= 1'b0;
    end else if (any_req) begin
      owner    <= {rs_wr_req, of_rd_req, cf_rd_req};
      bus_busy <= 1'b1;
    end else if (read_dn || write_dn) begin
      owner    <= '0;
      bus_busy <= 1'b0;
    end
  end

  a_single_req: assert property (@(posedge clk) disable iff (rst)
    $onehot0({cf_rd_req, of_rd_req, rs_wr_req}))
    else $error("bus_owner: two stages requested at once");

  a_req_when_free: assert property (@(posedge clk) disable iff (rst)
    any_req |-> !bus_busy)
    else $error("bus_owner: request while the bus is busy");

endmodule

//--- source/result_store.sv
`timescale 1ns/1ps

module result_store import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              res_valid,
  input  cmd_word_u         res_cmd,
  input  logic [data_w-1:0] result,
  input  logic              take_jump,
  input  logic [addr_w-1:0] cmd_ptr,
  input  logic              rs_wr_dn,
  output logic              rs_wr_req,
  output logic [addr_w-1:0] rs_addr,
  output logic [data_w-1:0] wdata,
  output logic [addr_w-1:0] base_addr,
  output logic              next_valid,
  output logic [addr_w-1:0] next_ptr,
  output logic [7:0]        cpu_msg,
  output logic              msg_valid,
  output logic              halted
);

  logic wr_pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      rs_wr_req  <= 1'b0;
      next_valid <= 1'b0;
      msg_valid  <= 1'b0;
      halted     <= 1'b0;
      wr_pend    <= 1'b0;
      base_addr  <= '0;
      cpu_msg    <= '0;
    end else begin
      rs_wr_req  <= 1'b0;
      next_valid <= 1'b0;
      msg_valid  <= 1'b0;
      if (res_valid) begin
        if (is_arith(res_cmd.arith.opcode)) begin
          rs_wr_req <= 1'b1;
          wr_pend   <= 1'b1;
        end else begin
          case (res_cmd.ctrl.opcode)
            op_base: begin
              base_addr  <= res_cmd.ctrl.target;
              next_valid <= 1'b1;
            end
            op_msg: begin
              cpu_msg    <= res_cmd.ctrl.arg;
              msg_valid  <= 1'b1;
              next_valid <= 1'b1;
            end
            // stop here, no further fetch
            op_halt: halted <= 1'b1;
            default: next_valid <= 1'b1;
          endcase
        end
      end
      if (rs_wr_dn && wr_pend) begin
        wr_pend    <= 1'b0;
        next_valid <= 1'b1;
      end
    end
  end

  // result address and next pointer
  always_ff @(posedge clk) begin
    if (res_valid) begin
      rs_addr  <= base_addr + addr_w'(res_cmd.arith.dst_off);
      wdata    <= result;
      next_ptr <= take_jump ? res_cmd.ctrl.target : cmd_ptr + 1'b1;
    end
  end

  // once halted, the core must stay off the bus
  a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
    halted |-> !rs_wr_req && !next_valid)
    else $error("result_store: activity after halt");

endmodule

//--- source/alu_exec.sv
`timescale 1ns/1ps

module alu_exec import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              opnd_valid,
  input  cmd_word_u         opnd_cmd,
  input  logic [data_w-1:0] opnd_a,
  input  logic [data_w-1:0] opnd_b,
  output logic              res_valid,
  output cmd_word_u         res_cmd,
  output logic [data_w-1:0] result,
  output logic              take_jump
);

  logic [data_w-1:0] alu_out;

  // a is src1, b is src0
  always_comb begin
    case (opnd_cmd.arith.opcode)
      op_add:  alu_out = opnd_a + opnd_b;
      op_sub:  alu_out = opnd_a - opnd_b;
      op_and:  alu_out = opnd_a & opnd_b;
      op_or:   alu_out = opnd_a | opnd_b;
      op_xor:  alu_out = opnd_a ^ opnd_b;
      op_shl:  alu_out = opnd_a << opnd_b[4:0];
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      take_jump <= 1'b0;
    end else begin
      res_valid <= opnd_valid;
      if (opnd_valid) begin
        take_jump <= (opnd_cmd.ctrl.opcode == op_jnz) && (opnd_a != '0);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (opnd_valid) begin
      res_cmd <= opnd_cmd;
      result  <= alu_out;
    end
  end

endmodule

//--- source/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid,
  input  cmd_word_u         cmd,
  input  logic [addr_w-1:0] base_addr,
  input  logic              of_rd_dn,
  input  logic [data_w-1:0] rdata,
  output logic              of_rd_req,
  output logic [addr_w-1:0] of_addr,
  output logic              opnd_valid,
  output cmd_word_u         opnd_cmd,
  output logic [data_w-1:0] opnd_a,
  output logic [data_w-1:0] opnd_b
);

  logic [1:0] state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= of_idle;
      of_rd_req  <= 1'b0;
      opnd_valid <= 1'b0;
    end else begin
      of_rd_req  <= 1'b0;
      opnd_valid <= 1'b0;
      case (state)
        of_idle: begin
          if (cmd_valid) begin
            if (is_arith(cmd.arith.opcode) || cmd.ctrl.opcode == op_jnz) begin
              of_rd_req <= 1'b1;
              state     <= of_wait_a;
            end else begin
              // nothing to read
              opnd_valid <= 1'b1;
            end
          end
        end
        of_wait_a: begin
          if (of_rd_dn) begin
            if (is_arith(opnd_cmd.arith.opcode)) begin
              of_rd_req <= 1'b1;
              state     <= of_wait_b;
            end else begin
              opnd_valid <= 1'b1;
              state      <= of_idle;
            end
          end
        end
        of_wait_b: begin
          if (of_rd_dn) begin
            opnd_valid <= 1'b1;
            state      <= of_idle;
          end
        end
        default: state <= of_idle;
      endcase
    end
  end

  // addresses and operands
  always_ff @(posedge clk) begin
    if (cmd_valid && state == of_idle) begin
      opnd_cmd <= cmd;
      // jnz tests the word at arg, arithmetic starts with src1
      if (cmd.ctrl.opcode == op_jnz) begin
        of_addr <= base_addr + addr_w'(cmd.ctrl.arg);
      end else begin
        of_addr <= base_addr + addr_w'(cmd.arith.src1_off);
      end
    end
    if (of_rd_dn && state == of_wait_a) begin
      opnd_a  <= rdata;
      of_addr <= base_addr + addr_w'(opnd_cmd.arith.src0_off);
    end
    if (of_rd_dn && state == of_wait_b) begin
      opnd_b <= rdata;
    end
  end

  // one command in flight, fetch must not send another while we work
  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    cmd_valid |-> state == of_idle)
    else $error("operand_fetch: new command while busy");

endmodule

//--- source/cmd_fetch.sv
`timescale 1ns/1ps

module cmd_fetch import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              next_valid,
  input  logic [addr_w-1:0] next_ptr,
  input  logic              cf_rd_dn,
  input  logic [data_w-1:0] rdata,
  output logic              cf_rd_req,
  output logic [addr_w-1:0] cf_addr,
  output logic              cmd_valid,
  output cmd_word_u         cmd
);

  logic [addr_w-1:0] cmd_ptr;
  // kicks off the very first fetch
  logic              boot;
  logic              rd_pend;

  // pointer is held until the store stage redirects it
  assign cf_addr = cmd_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_ptr   <= '0;
      boot      <= 1'b1;
      rd_pend   <= 1'b0;
      cf_rd_req <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      boot      <= 1'b0;
      cf_rd_req <= boot | next_valid;
      cmd_valid <= cf_rd_dn;
      if (next_valid) begin
        cmd_ptr <= next_ptr;
      end
      if (cf_rd_req) begin
        rd_pend <= 1'b1;
      end else if (cf_rd_dn) begin
        rd_pend <= 1'b0;
      end
    end
  end

  // latch the fetched word
  always_ff @(posedge clk) begin
    if (cf_rd_dn) begin
      cmd <= rdata;
    end
  end

  // done routed back by the bus owner must match our own read
  a_dn_pending: assert property (@(posedge clk) disable iff (rst) cf_rd_dn |-> rd_pend)
    else $error("cmd_fetch: read done without a pending read");

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

  localparam int addr_w = 16;
  localparam int data_w = 32;
  localparam int off_w  = 8;
  localparam int op_w   = 4;

  // opcodes, unlisted codes are no-ops
  localparam logic [op_w-1:0] op_add  = 4'h1;
  localparam logic [op_w-1:0] op_sub  = 4'h2;
  localparam logic [op_w-1:0] op_and  = 4'h3;
  localparam logic [op_w-1:0] op_or   = 4'h4;
  localparam logic [op_w-1:0] op_xor  = 4'h5;
  localparam logic [op_w-1:0] op_shl  = 4'h6;
  localparam logic [op_w-1:0] op_jnz  = 4'h7;
  localparam logic [op_w-1:0] op_base = 4'h8;
  localparam logic [op_w-1:0] op_msg  = 4'h9;
  localparam logic [op_w-1:0] op_halt = 4'hf;

  // operand fetch FSM states
  localparam logic [1:0] of_idle   = 2'd0;
  localparam logic [1:0] of_wait_a = 2'd1;
  localparam logic [1:0] of_wait_b = 2'd2;

  // command word, opcode sits in bits 31:28 in both views
  typedef union packed {
    struct packed {
      logic [op_w-1:0]  opcode;
      logic [3:0]       spare;
      logic [off_w-1:0] dst_off;
      logic [off_w-1:0] src1_off;
      logic [off_w-1:0] src0_off;
    } arith;
    struct packed {
      logic [op_w-1:0]   opcode;
      logic [3:0]        spare;
      logic [addr_w-1:0] target;
      logic [off_w-1:0]  arg;
    } ctrl;
  } cmd_word_u;

  // two-operand commands with a memory result
  function automatic logic is_arith(logic [op_w-1:0] op);
    return op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl};
  endfunction

endpackage
